/* src.f */
design/game_pkg.sv
design/vga_timing.sv
design/gamepad_receiver.sv
design/line_merger.sv
design/board_engine.sv
design/tile_renderer.sv
design/game_top.sv
testbench/tb_clock_gen.sv
testbench/tb_game_top.sv

/* testbench/tb_game_top.sv */
`timescale 1ns/1ps

module tb_game_top;

  // Small frame: 4x16 + 4+8+4 by 4x12 + 2+2+2
  localparam int cell_w = 16;
  localparam int cell_h = 12;
  localparam int border_w = 2;
  localparam int act_w = 4 * cell_w;
  localparam int act_h = 4 * cell_h;
  localparam int h_total = act_w + 4 + 8 + 4;
  localparam int v_total = act_h + 2 + 2 + 2;
  localparam int frame_cycles = h_total * v_total;
  // 12 bits of 8 cycles, latch pulse, two frames
  localparam int word_cycles = 12 * 8 + 4 + 2 * frame_cycles;
  localparam int num_words = 54;
  localparam int timeout_cycles = 2 * (num_words * word_cycles + 4 * frame_cycles);

  logic clk;
  logic rst_n;
  logic pad_data;
  logic pad_clk;
  logic pad_latch;
  logic hsync;
  logic vsync;
  logic [1:0] red;
  logic [1:0] green;
  logic [1:0] blue;

  int hcnt;
  int vcnt;
  int cycles;
  integer seed;
  string test_name;
  logic color_check_en;
  logic [63:0] ref_board;
  // Direction levels seen by the model, {up, down, left, right}
  logic [3:0] pad_dirs;

  tb_clock_gen #(.reset_cycles(4)) u_clk (
    .clk  (clk),
    .rst_n(rst_n)
  );

  game_top #(
    .cell_w  (cell_w),
    .cell_h  (cell_h),
    .border_w(border_w),
    .h_front (4),
    .h_sync  (8),
    .h_back  (4),
    .v_front (2),
    .v_sync  (2),
    .v_back  (2)
  ) dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .pad_data (pad_data),
    .pad_clk  (pad_clk),
    .pad_latch(pad_latch),
    .hsync    (hsync),
    .vsync    (vsync),
    .red      (red),
    .green    (green),
    .blue     (blue)
  );

  task automatic check_eq(input string what, input int expected, input int actual);
    if (expected != actual) begin
      $display("FAIL %s %s expected %0h actual %0h", test_name, what, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Palette table from the color list
  function automatic logic [5:0] palette(input logic [3:0] value);
    case (value)
      4'd1: return game_pkg::color_red;
      4'd2: return game_pkg::color_orange;
      4'd3: return game_pkg::color_yellow;
      4'd4: return game_pkg::color_lime;
      4'd5: return game_pkg::color_green;
      4'd6: return game_pkg::color_teal;
      4'd7: return game_pkg::color_cyan;
      4'd8: return game_pkg::color_blue;
      4'd9: return game_pkg::color_magenta;
      4'd10: return game_pkg::color_pink;
      4'd11: return game_pkg::color_white;
      default: return game_pkg::color_black;
    endcase
  endfunction

  // Board slot of position p along line l, dir 0..3 is up, down, left, right
  function automatic int cell_slot(input int dir, input int l, input int p);
    int x;
    int y;
    case (dir)
      0: begin
        x = l;
        y = p;
      end
      1: begin
        x = l;
        y = 3 - p;
      end
      2: begin
        x = p;
        y = l;
      end
      default: begin
        x = 3 - p;
        y = l;
      end
    endcase
    return x * 4 + y;
  endfunction

  // Slide toward index 0, each tile merges at most once
  function automatic logic [15:0] ref_merge(input logic [15:0] line);
    logic [3:0] tiles [4];
    logic [15:0] res;
    int cnt;
    int i;
    int k;
    res = '0;
    cnt = 0;
    for (int j = 0; j < 4; j++) begin
      if (line[4*j +: 4] != 4'd0) begin
        tiles[cnt] = line[4*j +: 4];
        cnt++;
      end
    end
    i = 0;
    k = 0;
    while (i < cnt) begin
      if (i + 1 < cnt && tiles[i] == tiles[i+1]) begin
        // 4-bit result wraps at 16
        res[4*k +: 4] = tiles[i] + 4'd1;
        i += 2;
      end else begin
        res[4*k +: 4] = tiles[i];
        i += 1;
      end
      k++;
    end
    return res;
  endfunction

  function automatic logic [63:0] ref_move(input logic [63:0] b, input int dir);
    logic [63:0] res;
    logic [15:0] line;
    res = b;
    for (int l = 0; l < 4; l++) begin
      for (int p = 0; p < 4; p++) begin
        line[4*p +: 4] = b[4*cell_slot(dir, l, p) +: 4];
      end
      line = ref_merge(line);
      for (int p = 0; p < 4; p++) begin
        res[4*cell_slot(dir, l, p) +: 4] = line[4*p +: 4];
      end
    end
    return res;
  endfunction

  function automatic logic [5:0] ref_color(input int h, input int v, input logic [63:0] b);
    int slot;
    if (h >= act_w || v >= act_h) begin
      return game_pkg::color_black;
    end
    if (h % cell_w < border_w || v % cell_h < border_w ||
        h >= act_w - border_w || v >= act_h - border_w) begin
      return game_pkg::border_color;
    end
    slot = (h / cell_w) * 4 + (v / cell_h);
    return palette(b[4*slot +: 4]);
  endfunction

  // Serialize MSB first, latch, then let two frames go by
  task automatic send_word(input logic [11:0] word);
    logic [3:0] dirs;
    logic [3:0] rise;
    for (int i = 11; i >= 0; i--) begin
      pad_data = word[i];
      pad_clk = 1'b0;
      step(4);
      pad_clk = 1'b1;
      step(4);
    end
    pad_clk = 1'b0;
    color_check_en = 1'b0;
    pad_latch = 1'b1;
    step(4);
    pad_latch = 1'b0;
    step(frame_cycles);
    // All ones means no controller
    dirs = (word == 12'hfff) ? 4'b0000 : word[7:4];
    rise = dirs & ~pad_dirs;
    pad_dirs = dirs;
    // Only one move, up first
    if (rise[3]) begin
      ref_board = ref_move(ref_board, 0);
    end else if (rise[2]) begin
      ref_board = ref_move(ref_board, 1);
    end else if (rise[1]) begin
      ref_board = ref_move(ref_board, 2);
    end else if (rise[0]) begin
      ref_board = ref_move(ref_board, 3);
    end
    color_check_en = 1'b1;
    step(frame_cycles);
  endtask

  // Press then release, dir 0..3 is up, down, left, right
  task automatic press(input int dir);
    send_word(12'h080 >> dir);
    send_word(12'h000);
  endtask

  // Pixel counters as the timing rule defines them
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hcnt <= 0;
      vcnt <= 0;
    end else if (hcnt == h_total - 1) begin
      hcnt <= 0;
      vcnt <= (vcnt == v_total - 1) ? 0 : vcnt + 1;
    end else begin
      hcnt <= hcnt + 1;
    end
  end

  // Outputs settle after the rising edge, sample on the falling one
  always @(negedge clk) begin
    if (rst_n) begin
      check_eq("hsync", !(hcnt >= act_w + 4 && hcnt < act_w + 12), hsync);
      check_eq("vsync", !(vcnt >= act_h + 2 && vcnt < act_h + 4), vsync);
      // Blanking is black whatever the board holds
      if (color_check_en || hcnt >= act_w || vcnt >= act_h) begin
        check_eq("color", ref_color(hcnt, vcnt, ref_board), {red, green, blue});
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("RESULT: FAIL");
      $fatal(1, "Timeout");
    end
  end

  initial begin
    pad_data = 1'b0;
    pad_clk = 1'b0;
    pad_latch = 1'b0;
    cycles = 0;
    seed = 75831;
    pad_dirs = 4'b0000;
    color_check_en = 1'b1;
    // Reset pattern, slot x*4+y
    ref_board = '0;
    ref_board[4*(1*4+1) +: 4] = 4'd1;
    ref_board[4*(1*4+3) +: 4] = 4'd1;
    ref_board[4*(1*4+2) +: 4] = 4'd2;
    ref_board[4*(3*4+0) +: 4] = 4'd2;
    ref_board[4*(3*4+3) +: 4] = 4'd2;
    for (int y = 0; y < 3; y++) begin
      ref_board[4*(0*4+y) +: 4] = 4'd5;
    end
    for (int y = 0; y < 4; y++) begin
      ref_board[4*(2*4+y) +: 4] = 4'd9;
    end

    test_name = "sync_timing";
    #1;
    check_eq("hsync in reset", 1, hsync);
    check_eq("vsync in reset", 1, vsync);
    @(posedge rst_n);
    test_name = "initial_board";
    step(2 * frame_cycles);

    test_name = "single_moves";
    press(2);
    press(3);
    press(0);
    press(1);

    // Second latched word keeps left held
    // Board after a left slide still moves on up, so a stray up shows below
    test_name = "held_button";
    send_word(12'h020);
    send_word(12'h020);
    send_word(12'h000);

    test_name = "absent_and_other_buttons";
    send_word(12'hfff);
    send_word(12'hf0f);
    send_word(12'h000);

    test_name = "random_play";
    for (int i = 0; i < 20; i++) begin
      press($unsigned($random(seed)) % 4);
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int reset_cycles = 4
) (
  output logic clk,
  output logic rst_n
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Release 1 ns after a rising edge, like the other inputs
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

/* design/game_top.sv */
`timescale 1ns/1ps

module game_top #(
  parameter int cell_w = 160,
  parameter int cell_h = 120,
  parameter int border_w = 4,
  parameter int h_front = 16,
  parameter int h_sync = 96,
  parameter int h_back = 48,
  parameter int v_front = 10,
  parameter int v_sync = 2,
  parameter int v_back = 33
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       pad_data,
  input  logic       pad_clk,
  input  logic       pad_latch,
  output logic       hsync,
  output logic       vsync,
  output logic [1:0] red,
  output logic [1:0] green,
  output logic [1:0] blue
);

  // Active area is four cells each way
  localparam int h_active = game_pkg::grid_dim * cell_w;
  localparam int v_active = game_pkg::grid_dim * cell_h;

  logic video_on;
  game_pkg::coord_t hpos;
  game_pkg::coord_t vpos;
  logic pad_up;
  logic pad_down;
  logic pad_left;
  logic pad_right;
  game_pkg::board_t board;

  vga_timing #(
    .h_active(h_active),
    .h_front (h_front),
    .h_sync  (h_sync),
    .h_back  (h_back),
    .v_active(v_active),
    .v_front (v_front),
    .v_sync  (v_sync),
    .v_back  (v_back)
  ) u_timing (
    .clk     (clk),
    .rst_n   (rst_n),
    .hsync   (hsync),
    .vsync   (vsync),
    .video_on(video_on),
    .hpos    (hpos),
    .vpos    (vpos)
  );

  gamepad_receiver u_pad (
    .clk      (clk),
    .rst_n    (rst_n),
    .pad_data (pad_data),
    .pad_clk  (pad_clk),
    .pad_latch(pad_latch),
    .pad_up   (pad_up),
    .pad_down (pad_down),
    .pad_left (pad_left),
    .pad_right(pad_right)
  );

  // Game state, moves on new direction presses
  board_engine u_board (
    .clk      (clk),
    .rst_n    (rst_n),
    .pad_up   (pad_up),
    .pad_down (pad_down),
    .pad_left (pad_left),
    .pad_right(pad_right),
    .board    (board)
  );

  tile_renderer #(
    .cell_w  (cell_w),
    .cell_h  (cell_h),
    .border_w(border_w)
  ) u_render (
    .video_on(video_on),
    .hpos    (hpos),
    .vpos    (vpos),
    .board   (board),
    .red     (red),
    .green   (green),
    .blue    (blue)
  );

endmodule

/* design/tile_renderer.sv */
`timescale 1ns/1ps

module tile_renderer #(
  parameter int cell_w = 160,
  parameter int cell_h = 120,
  parameter int border_w = 4
) (
  input  logic             video_on,
  input  game_pkg::coord_t hpos,
  input  game_pkg::coord_t vpos,
  input  game_pkg::board_t board,
  output logic [1:0]       red,
  output logic [1:0]       green,
  output logic [1:0]       blue
);

  // Active area size
  localparam int act_w = game_pkg::grid_dim * cell_w;
  localparam int act_h = game_pkg::grid_dim * cell_h;

  game_pkg::coord_t cell_x;
  game_pkg::coord_t cell_y;
  game_pkg::coord_t off_x;
  game_pkg::coord_t off_y;
  logic [3:0] slot;
  game_pkg::tile_t tile;
  logic border;
  game_pkg::color_t color;

  // Cell index and offset inside the cell
  assign cell_x = game_pkg::coord_t'(hpos / cell_w);
  assign cell_y = game_pkg::coord_t'(vpos / cell_h);
  assign off_x = game_pkg::coord_t'(hpos % cell_w);
  assign off_y = game_pkg::coord_t'(vpos % cell_h);

  // Slot x*4+y, only meaningful inside the active area
  assign slot = {cell_x[1:0], cell_y[1:0]};
  assign tile = board[slot*game_pkg::tile_w +: game_pkg::tile_w];

  // Left and top band of every cell, plus the closing right and bottom band
  assign border = (off_x < border_w) || (off_y < border_w) ||
                  (hpos >= act_w - border_w) || (vpos >= act_h - border_w);

  always_comb begin
    if (!video_on) begin
      color = game_pkg::color_black;
    end else if (border) begin
      color = game_pkg::border_color;
    end else begin
      color = game_pkg::tile_color(tile);
    end
  end

  assign {red, green, blue} = color;

endmodule

/* design/board_engine.sv */
`timescale 1ns/1ps

module board_engine (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             pad_up,
  input  logic             pad_down,
  input  logic             pad_left,
  input  logic             pad_right,
  output game_pkg::board_t board
);

  localparam int n = game_pkg::grid_dim;
  localparam int tw = game_pkg::tile_w;

  // Starting layout, slot 15 in the top nibble
  localparam game_pkg::board_t reset_board = 64'h2002_9999_1210_0555;

  // Direction codes
  localparam logic [1:0] dir_up = 2'd0;
  localparam logic [1:0] dir_down = 2'd1;
  localparam logic [1:0] dir_left = 2'd2;
  localparam logic [1:0] dir_right = 2'd3;

  logic up_prev;
  logic down_prev;
  logic left_prev;
  logic right_prev;
  logic move_req;
  logic [1:0] move_dir;

  game_pkg::line_t lines_in [n];
  game_pkg::line_t lines_out [n];
  game_pkg::board_t board_next;

  // Board slot of position p in line l for a direction
  function automatic int slot_of(input logic [1:0] dir, input int l, input int p);
    case (dir)
      dir_up: return l*n + p;
      dir_down: return l*n + (n-1-p);
      dir_left: return p*n + l;
      default: return (n-1-p)*n + l;
    endcase
  endfunction

  // Level history for the rising edges
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      up_prev <= 1'b0;
      down_prev <= 1'b0;
      left_prev <= 1'b0;
      right_prev <= 1'b0;
    end else begin
      up_prev <= pad_up;
      down_prev <= pad_down;
      left_prev <= pad_left;
      right_prev <= pad_right;
    end
  end

  // One move per cycle, up beats down beats left beats right
  always_comb begin
    move_req = 1'b1;
    move_dir = dir_up;
    if (pad_up && !up_prev) begin
      move_dir = dir_up;
    end else if (pad_down && !down_prev) begin
      move_dir = dir_down;
    end else if (pad_left && !left_prev) begin
      move_dir = dir_left;
    end else if (pad_right && !right_prev) begin
      move_dir = dir_right;
    end else begin
      move_req = 1'b0;
    end
  end

  // Gather lines in slide order
  always_comb begin
    for (int l = 0; l < n; l++) begin
      for (int p = 0; p < n; p++) begin
        lines_in[l][p*tw +: tw] = board[slot_of(move_dir, l, p)*tw +: tw];
      end
    end
  end

  for (genvar g = 0; g < n; g++) begin : g_merge
    line_merger u_merge (
      .line_in (lines_in[g]),
      .line_out(lines_out[g])
    );
  end

  // Scatter merged lines back, every slot written once
  always_comb begin
    board_next = board;
    for (int l = 0; l < n; l++) begin
      for (int p = 0; p < n; p++) begin
        board_next[slot_of(move_dir, l, p)*tw +: tw] = lines_out[l][p*tw +: tw];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      board <= reset_board;
    end else if (move_req) begin
      board <= board_next;
    end
  end

endmodule

/* design/line_merger.sv */
`timescale 1ns/1ps

module line_merger (
  input  game_pkg::line_t line_in,
  output game_pkg::line_t line_out
);

  localparam int n = game_pkg::grid_dim;
  localparam int tw = game_pkg::tile_w;

  // Compacted tiles, one spare empty entry past the end
  game_pkg::tile_t packed_tiles [n+1];
  game_pkg::tile_t cur;
  int unsigned fill;
  int unsigned out_idx;
  logic skip;

  always_comb begin
    // Slide: non-zero tiles toward index 0 in order
    for (int i = 0; i <= n; i++) begin
      packed_tiles[i] = '0;
    end
    fill = 0;
    for (int i = 0; i < n; i++) begin
      cur = line_in[i*tw +: tw];
      if (cur != '0) begin
        packed_tiles[fill] = cur;
        fill = fill + 1;
      end
    end

    // Merge pairs from index 0 up
    line_out = '0;
    out_idx = 0;
    skip = 1'b0;
    for (int i = 0; i < n; i++) begin
      if (skip) begin
        // Partner already folded into the previous tile
        skip = 1'b0;
      end else if (packed_tiles[i] != '0) begin
        if (packed_tiles[i+1] == packed_tiles[i]) begin
          // Exponent plus one, wraps at 16
          line_out[out_idx*tw +: tw] = packed_tiles[i] + 1'b1;
          skip = 1'b1;
        end else begin
          line_out[out_idx*tw +: tw] = packed_tiles[i];
        end
        out_idx = out_idx + 1;
      end
    end
  end

endmodule

/* design/gamepad_receiver.sv */
`timescale 1ns/1ps

module gamepad_receiver (
  input  logic clk,
  input  logic rst_n,
  input  logic pad_data,
  input  logic pad_clk,
  input  logic pad_latch,
  output logic pad_up,
  output logic pad_down,
  output logic pad_left,
  output logic pad_right
);

  // Two-flop synchronizers, bit 1 is the stable copy
  logic [1:0] data_sync;
  logic [1:0] clk_sync;
  logic [1:0] latch_sync;

  // Previous synchronized levels for edge detection
  logic clk_prev;
  logic latch_prev;
  logic clk_rise;
  logic latch_rise;

  game_pkg::pad_word_t shift_reg;
  game_pkg::pad_word_t pad_word;
  logic present;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_sync <= '0;
      clk_sync <= '0;
      latch_sync <= '0;
      clk_prev <= 1'b0;
      latch_prev <= 1'b0;
    end else begin
      data_sync <= {data_sync[0], pad_data};
      clk_sync <= {clk_sync[0], pad_clk};
      latch_sync <= {latch_sync[0], pad_latch};
      clk_prev <= clk_sync[1];
      latch_prev <= latch_sync[1];
    end
  end

  assign clk_rise = clk_sync[1] & ~clk_prev;
  assign latch_rise = latch_sync[1] & ~latch_prev;

  // Shift in MSB first, latch the finished word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // All ones reads as no controller until the first latch
      shift_reg <= game_pkg::pad_absent_word;
      pad_word <= game_pkg::pad_absent_word;
    end else begin
      if (clk_rise) begin
        shift_reg <= {shift_reg[$bits(game_pkg::pad_word_t)-2:0], data_sync[1]};
      end
      if (latch_rise) begin
        pad_word <= shift_reg;
      end
    end
  end

  // Presence check covers the whole word, other buttons included
  assign present = (pad_word != game_pkg::pad_absent_word);

  assign pad_up = present & pad_word[game_pkg::btn_up_bit];
  assign pad_down = present & pad_word[game_pkg::btn_down_bit];
  assign pad_left = present & pad_word[game_pkg::btn_left_bit];
  assign pad_right = present & pad_word[game_pkg::btn_right_bit];

endmodule

/* design/vga_timing.sv */
`timescale 1ns/1ps

module vga_timing #(
  parameter int h_active = 640,
  parameter int h_front = 16,
  parameter int h_sync = 96,
  parameter int h_back = 48,
  parameter int v_active = 480,
  parameter int v_front = 10,
  parameter int v_sync = 2,
  parameter int v_back = 33
) (
  input  logic             clk,
  input  logic             rst_n,
  output logic             hsync,
  output logic             vsync,
  output logic             video_on,
  output game_pkg::coord_t hpos,
  output game_pkg::coord_t vpos
);

  // Full line and frame lengths
  localparam int h_total = h_active + h_front + h_sync + h_back;
  localparam int v_total = v_active + v_front + v_sync + v_back;

  // Counter thresholds
  localparam game_pkg::coord_t h_last = game_pkg::coord_t'(h_total - 1);
  localparam game_pkg::coord_t v_last = game_pkg::coord_t'(v_total - 1);
  localparam game_pkg::coord_t h_sync_start = game_pkg::coord_t'(h_active + h_front);
  localparam game_pkg::coord_t h_sync_end = game_pkg::coord_t'(h_active + h_front + h_sync);
  localparam game_pkg::coord_t v_sync_start = game_pkg::coord_t'(v_active + v_front);
  localparam game_pkg::coord_t v_sync_end = game_pkg::coord_t'(v_active + v_front + v_sync);

  logic h_wrap;

  // End of line
  assign h_wrap = (hpos == h_last);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hpos <= '0;
      vpos <= '0;
    end else if (h_wrap) begin
      hpos <= '0;
      // Next line, or back to the top of the frame
      if (vpos == v_last) begin
        vpos <= '0;
      end else begin
        vpos <= vpos + 1'b1;
      end
    end else begin
      hpos <= hpos + 1'b1;
    end
  end

  // Sync pulses are active low
  assign hsync = !((hpos >= h_sync_start) && (hpos < h_sync_end));
  assign vsync = !((vpos >= v_sync_start) && (vpos < v_sync_end));

  // Visible window
  assign video_on = (hpos < game_pkg::coord_t'(h_active)) &&
                    (vpos < game_pkg::coord_t'(v_active));

endmodule

/* design/game_pkg.sv */
package game_pkg;

  // Board geometry
  localparam int grid_dim = 4;
  localparam int tile_w = 4;

  // Tile exponent, 0 is an empty tile
  typedef logic [tile_w-1:0] tile_t;
  // Four tiles in slide order, index 0 in the low nibble
  typedef logic [grid_dim*tile_w-1:0] line_t;
  // Tile (x, y) lives in slot x*4+y
  typedef logic [grid_dim*grid_dim*tile_w-1:0] board_t;
  typedef logic [9:0] coord_t;
  // Packed as {red, green, blue}, 2 bits each
  typedef logic [5:0] color_t;
  // First serial bit lands in the MSB
  typedef logic [11:0] pad_word_t;

  // Direction button positions in the pad word
  localparam int btn_up_bit = 7;
  localparam int btn_down_bit = 6;
  localparam int btn_left_bit = 5;
  localparam int btn_right_bit = 4;

  // Pulled-up data line reads as all ones with no controller
  localparam pad_word_t pad_absent_word = '1;

  // Palette
  localparam color_t color_black = {2'b00, 2'b00, 2'b00};
  localparam color_t color_red = {2'b11, 2'b00, 2'b00};
  localparam color_t color_orange = {2'b11, 2'b10, 2'b00};
  localparam color_t color_yellow = {2'b11, 2'b11, 2'b00};
  localparam color_t color_lime = {2'b10, 2'b11, 2'b00};
  localparam color_t color_green = {2'b00, 2'b11, 2'b00};
  localparam color_t color_teal = {2'b00, 2'b11, 2'b10};
  localparam color_t color_cyan = {2'b00, 2'b11, 2'b11};
  localparam color_t color_blue = {2'b00, 2'b00, 2'b11};
  localparam color_t color_magenta = {2'b11, 2'b00, 2'b11};
  localparam color_t color_pink = {2'b11, 2'b01, 2'b11};
  localparam color_t color_white = {2'b11, 2'b11, 2'b11};
  localparam color_t border_color = {2'b10, 2'b10, 2'b10};

  // Tile value to palette entry, 12 and up fall back to black
  function automatic color_t tile_color(input tile_t value);
    case (value)
      4'd1: return color_red;
      4'd2: return color_orange;
      4'd3: return color_yellow;
      4'd4: return color_lime;
      4'd5: return color_green;
      4'd6: return color_teal;
      4'd7: return color_cyan;
      4'd8: return color_blue;
      4'd9: return color_magenta;
      4'd10: return color_pink;
      4'd11: return color_white;
      default: return color_black;
    endcase
  endfunction

endpackage
